//--- source/core_pkg.sv
package core_pkg;

    // basic data word: addresses, data, pc, instruction, csr values
    typedef logic [31:0] word_t;

    // unique tag carried by every instruction in flight
    typedef logic [63:0] inst_id_t;

    // byte-lane write strobe, one bit per byte of word_t
    typedef logic [3:0] strb_t;

    // memory operation of the instruction in the memory stage
    typedef enum logic [3:0] {
        MEM_NONE      = 4'd0,
        MEM_LB        = 4'd1,
        MEM_LBU       = 4'd2,
        MEM_LH        = 4'd3,
        MEM_LHU       = 4'd4,
        MEM_LW        = 4'd5,
        MEM_SB        = 4'd6,
        MEM_SH        = 4'd7,
        MEM_SW        = 4'd8,
        MEM_AMOSWAP_W = 4'd9
    } mem_op_t;

    // memory stage access sequencing
    typedef enum logic [1:0] {
        ST_IDLE       = 2'd0,
        ST_WAIT_READY = 2'd1,
        ST_WAIT_RDATA = 2'd2
    } mem_state_t;

    // data memory size in words
    localparam int DMEM_WORDS = 256;

    // word index width, taken from address bits 9 down to 2
    localparam int DMEM_ADDR_BITS = 8;

    // cycles from read acceptance to the response pulse
    localparam int READ_LATENCY = 2;

    // width of the read latency countdown
    localparam int LAT_CNT_BITS = $clog2(READ_LATENCY + 1);

    // reset value of the saved tag
    // top 16 bits set so no real instruction ever matches it
    localparam inst_id_t INST_ID_NONE = 64'hffff_0000_0000_0000;

endpackage

//--- source/mem_stage.sv
`timescale 1ns/1ps

module mem_stage (
    input  logic               clk,
    input  logic               reset,

    // instruction from the execute side
    input  logic               mem_valid,
    input  core_pkg::word_t    mem_reg_pc,
    input  core_pkg::word_t    mem_inst,
    input  core_pkg::inst_id_t mem_inst_id,
    input  core_pkg::mem_op_t  mem_op,
    input  core_pkg::word_t    mem_rs2_data,
    input  core_pkg::word_t    mem_alu_out,
    input  core_pkg::word_t    mem_csr_rdata,

    // towards writeback
    output logic               mem_wb_valid,
    output core_pkg::word_t    mem_wb_reg_pc,
    output core_pkg::word_t    mem_wb_inst,
    output core_pkg::inst_id_t mem_wb_inst_id,
    output core_pkg::mem_op_t  mem_wb_op,
    output core_pkg::word_t    mem_wb_alu_out,
    output core_pkg::word_t    mem_wb_mem_rdata,
    output core_pkg::word_t    mem_wb_csr_rdata,

    input  logic               pipeline_flush,
    output logic               memory_unit_stall,

    // request channel
    output logic               dreq_valid,
    output logic               dreq_write,
    output core_pkg::word_t    dreq_addr,
    output core_pkg::word_t    dreq_wdata,
    output core_pkg::strb_t    dreq_strb,
    input  logic               dreq_ready,

    // response channel
    input  logic               dresp_valid,
    input  core_pkg::word_t    dresp_rdata
);

    import core_pkg::*;

    mem_state_t state;
    inst_id_t   saved_inst_id;
    logic       cmd_done;
    mem_op_t    replace_op;
    word_t      saved_rdata;

    logic       new_inst;
    logic       may_start;
    mem_op_t    cur_op;
    logic       is_store;
    logic       is_load;

    // sign or zero extension by the original op
    function automatic word_t extend_load(input mem_op_t op, input word_t raw);
        word_t result;
        case (op)
            MEM_LB:  result = {{24{raw[7]}}, raw[7:0]};
            MEM_LBU: result = {24'h0, raw[7:0]};
            MEM_LH:  result = {{16{raw[15]}}, raw[15:0]};
            MEM_LHU: result = {16'h0, raw[15:0]};
            // lw and the old word of a swap
            default: result = raw;
        endcase
        return result;
    endfunction

    assign new_inst  = saved_inst_id != mem_inst_id;
    assign may_start = !cmd_done || new_inst;

    // first cycle of a tag uses the decoded op, later cycles the replacement
    // which lets a swap become a word store after its read
    assign cur_op = !mem_valid ? MEM_NONE :
                    new_inst   ? mem_op   : replace_op;

    assign is_store = cur_op == MEM_SB || cur_op == MEM_SH || cur_op == MEM_SW;
    assign is_load  = cur_op == MEM_LB || cur_op == MEM_LBU || cur_op == MEM_LH ||
                      cur_op == MEM_LHU || cur_op == MEM_LW || cur_op == MEM_AMOSWAP_W;

    // request channel
    assign dreq_valid = state == ST_WAIT_READY && mem_valid && may_start &&
                        cur_op != MEM_NONE && !pipeline_flush;
    assign dreq_write = is_store;
    assign dreq_addr  = mem_alu_out;
    assign dreq_wdata = mem_rs2_data;

    always_comb begin
        case (cur_op)
            MEM_SB:  dreq_strb = 4'b0001;
            MEM_SH:  dreq_strb = 4'b0011;
            default: dreq_strb = 4'b1111;
        endcase
    end

    // held until the access sequence finishes
    assign memory_unit_stall = mem_valid &&
                               (state != ST_IDLE || (may_start && cur_op != MEM_NONE));

    assign mem_wb_valid     = mem_valid && !pipeline_flush && !memory_unit_stall;
    assign mem_wb_reg_pc    = mem_reg_pc;
    assign mem_wb_inst      = mem_inst;
    assign mem_wb_inst_id   = mem_inst_id;
    assign mem_wb_op        = mem_op;
    assign mem_wb_alu_out   = mem_alu_out;
    assign mem_wb_mem_rdata = extend_load(mem_op, saved_rdata);
    assign mem_wb_csr_rdata = mem_csr_rdata;

    always_ff @(posedge clk) begin
        if (reset) begin
            saved_inst_id <= INST_ID_NONE;
        end else if (mem_valid) begin
            saved_inst_id <= mem_inst_id;
        end
    end

    // read data is only taken while a response is expected
    always_ff @(posedge clk) begin
        if (state == ST_WAIT_RDATA && dresp_valid) begin
            saved_rdata <= dresp_rdata;
        end
    end

    always_ff @(posedge clk) begin
        if (reset || pipeline_flush || cur_op == MEM_NONE) begin
            state      <= ST_IDLE;
            cmd_done   <= 1'b0;
            replace_op <= MEM_NONE;
        end else begin
            case (state)
                ST_IDLE: begin
                    replace_op <= cur_op;
                    if (is_load || is_store) begin
                        state <= ST_WAIT_READY;
                    end
                end
                ST_WAIT_READY: begin
                    if (dreq_ready) begin
                        if (is_store) begin
                            state      <= ST_IDLE;
                            cmd_done   <= 1'b1;
                            replace_op <= MEM_NONE;
                        end else begin
                            state <= ST_WAIT_RDATA;
                        end
                    end
                end
                ST_WAIT_RDATA: begin
                    if (dresp_valid) begin
                        if (cur_op == MEM_AMOSWAP_W) begin
                            // write phase of the swap
                            state      <= ST_WAIT_READY;
                            cmd_done   <= 1'b0;
                            replace_op <= MEM_SW;
                        end else begin
                            state      <= ST_IDLE;
                            cmd_done   <= 1'b1;
                            replace_op <= MEM_NONE;
                        end
                    end
                end
                default: begin
                    state <= ST_IDLE;
                end
            endcase
        end
    end

endmodule

//--- source/data_sram.sv
`timescale 1ns/1ps

module data_sram (
    input  logic            clk,
    input  logic            reset,

    // request channel
    input  logic            dreq_valid,
    input  logic            dreq_write,
    input  core_pkg::word_t dreq_addr,
    input  core_pkg::word_t dreq_wdata,
    input  core_pkg::strb_t dreq_strb,
    output logic            dreq_ready,

    // response channel
    output logic            dresp_valid,
    output core_pkg::word_t dresp_rdata
);

    import core_pkg::*;

    word_t                     mem [DMEM_WORDS];
    logic [DMEM_ADDR_BITS-1:0] word_idx;
    logic                      accept;
    logic [LAT_CNT_BITS-1:0]   lat_cnt;
    word_t                     rdata_q;

    // word index from address bits 9..2
    assign word_idx = dreq_addr[DMEM_ADDR_BITS+1:2];
    assign accept   = dreq_valid && dreq_ready;

    // busy while a read is in flight
    // ready comes back in the response cycle
    assign dreq_ready  = lat_cnt <= LAT_CNT_BITS'(1);
    assign dresp_valid = lat_cnt == LAT_CNT_BITS'(1);
    assign dresp_rdata = rdata_q;

    // byte-strobed write at acceptance
    always_ff @(posedge clk) begin
        if (accept && dreq_write) begin
            for (int lane = 0; lane < 4; lane++) begin
                if (dreq_strb[lane]) begin
                    mem[word_idx][lane*8 +: 8] <= dreq_wdata[lane*8 +: 8];
                end
            end
        end
    end

    // read word sampled when the request is taken
    always_ff @(posedge clk) begin
        if (accept && !dreq_write) begin
            rdata_q <= mem[word_idx];
        end
    end

    // latency countdown, response when it reaches one
    always_ff @(posedge clk) begin
        if (reset) begin
            lat_cnt <= '0;
        end else if (accept && !dreq_write) begin
            lat_cnt <= LAT_CNT_BITS'(READ_LATENCY);
        end else if (lat_cnt != '0) begin
            lat_cnt <= lat_cnt - 1'b1;
        end
    end

endmodule

//--- source/mem_subsystem.sv
`timescale 1ns/1ps

module mem_subsystem (
    input  logic               clk,
    input  logic               reset,

    input  logic               mem_valid,
    input  core_pkg::word_t    mem_reg_pc,
    input  core_pkg::word_t    mem_inst,
    input  core_pkg::inst_id_t mem_inst_id,
    input  core_pkg::mem_op_t  mem_op,
    input  core_pkg::word_t    mem_rs2_data,
    input  core_pkg::word_t    mem_alu_out,
    input  core_pkg::word_t    mem_csr_rdata,

    output logic               mem_wb_valid,
    output core_pkg::word_t    mem_wb_reg_pc,
    output core_pkg::word_t    mem_wb_inst,
    output core_pkg::inst_id_t mem_wb_inst_id,
    output core_pkg::mem_op_t  mem_wb_op,
    output core_pkg::word_t    mem_wb_alu_out,
    output core_pkg::word_t    mem_wb_mem_rdata,
    output core_pkg::word_t    mem_wb_csr_rdata,

    input  logic               pipeline_flush,
    output logic               memory_unit_stall
);

    import core_pkg::*;

    // stage to memory
    logic  dreq_valid;
    logic  dreq_write;
    word_t dreq_addr;
    word_t dreq_wdata;
    strb_t dreq_strb;
    logic  dreq_ready;

    // memory to stage
    logic  dresp_valid;
    word_t dresp_rdata;

    mem_stage mem_stage_i (
        .clk               (clk),
        .reset             (reset),
        .mem_valid         (mem_valid),
        .mem_reg_pc        (mem_reg_pc),
        .mem_inst          (mem_inst),
        .mem_inst_id       (mem_inst_id),
        .mem_op            (mem_op),
        .mem_rs2_data      (mem_rs2_data),
        .mem_alu_out       (mem_alu_out),
        .mem_csr_rdata     (mem_csr_rdata),
        .mem_wb_valid      (mem_wb_valid),
        .mem_wb_reg_pc     (mem_wb_reg_pc),
        .mem_wb_inst       (mem_wb_inst),
        .mem_wb_inst_id    (mem_wb_inst_id),
        .mem_wb_op         (mem_wb_op),
        .mem_wb_alu_out    (mem_wb_alu_out),
        .mem_wb_mem_rdata  (mem_wb_mem_rdata),
        .mem_wb_csr_rdata  (mem_wb_csr_rdata),
        .pipeline_flush    (pipeline_flush),
        .memory_unit_stall (memory_unit_stall),
        .dreq_valid        (dreq_valid),
        .dreq_write        (dreq_write),
        .dreq_addr         (dreq_addr),
        .dreq_wdata        (dreq_wdata),
        .dreq_strb         (dreq_strb),
        .dreq_ready        (dreq_ready),
        .dresp_valid       (dresp_valid),
        .dresp_rdata       (dresp_rdata)
    );

    data_sram data_sram_i (
        .clk         (clk),
        .reset       (reset),
        .dreq_valid  (dreq_valid),
        .dreq_write  (dreq_write),
        .dreq_addr   (dreq_addr),
        .dreq_wdata  (dreq_wdata),
        .dreq_strb   (dreq_strb),
        .dreq_ready  (dreq_ready),
        .dresp_valid (dresp_valid),
        .dresp_rdata (dresp_rdata)
    );

endmodule

//--- bench/tb_mem_subsystem.sv
`timescale 1ns/1ps

module tb_mem_subsystem;

    import core_pkg::*;

    localparam int NUM_TESTS      = 16;
    localparam int TIMEOUT_CYCLES = 40;

    logic     clk;
    logic     reset;
    logic     mem_valid;
    word_t    mem_reg_pc;
    word_t    mem_inst;
    inst_id_t mem_inst_id;
    mem_op_t  mem_op;
    word_t    mem_rs2_data;
    word_t    mem_alu_out;
    word_t    mem_csr_rdata;
    logic     pipeline_flush;

    logic     mem_wb_valid;
    word_t    mem_wb_reg_pc;
    word_t    mem_wb_inst;
    inst_id_t mem_wb_inst_id;
    mem_op_t  mem_wb_op;
    word_t    mem_wb_alu_out;
    word_t    mem_wb_mem_rdata;
    word_t    mem_wb_csr_rdata;
    logic     memory_unit_stall;

    // stimulus and expected results, one row per test
    mem_op_t  tab_op    [NUM_TESTS];
    word_t    tab_addr  [NUM_TESTS];
    word_t    tab_bits  [NUM_TESTS];
    word_t    tab_wdata [NUM_TESTS];
    word_t    tab_rdata [NUM_TESTS];
    int       tab_stall [NUM_TESTS];
    int       tab_count;

    // reference copy of the data memory
    word_t       ref_mem [DMEM_WORDS];
    logic [15:0] lfsr;
    inst_id_t    next_id;

    // values of the instruction currently driven
    word_t    cur_pc;
    word_t    cur_inst;
    inst_id_t cur_id;
    mem_op_t  cur_op;
    word_t    cur_addr;
    word_t    cur_csr;

    int       errors;
    int       tests_run;
    int       tests_passed;
    bit       timed_out;

    mem_subsystem dut_i (
        .clk               (clk),
        .reset             (reset),
        .mem_valid         (mem_valid),
        .mem_reg_pc        (mem_reg_pc),
        .mem_inst          (mem_inst),
        .mem_inst_id       (mem_inst_id),
        .mem_op            (mem_op),
        .mem_rs2_data      (mem_rs2_data),
        .mem_alu_out       (mem_alu_out),
        .mem_csr_rdata     (mem_csr_rdata),
        .mem_wb_valid      (mem_wb_valid),
        .mem_wb_reg_pc     (mem_wb_reg_pc),
        .mem_wb_inst       (mem_wb_inst),
        .mem_wb_inst_id    (mem_wb_inst_id),
        .mem_wb_op         (mem_wb_op),
        .mem_wb_alu_out    (mem_wb_alu_out),
        .mem_wb_mem_rdata  (mem_wb_mem_rdata),
        .mem_wb_csr_rdata  (mem_wb_csr_rdata),
        .pipeline_flush    (pipeline_flush),
        .memory_unit_stall (memory_unit_stall)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    // 16-bit galois lfsr, taps 16 14 13 11
    function automatic logic [15:0] lfsr_step(input logic [15:0] s);
        if (s[0]) begin
            return (s >> 1) ^ 16'hb400;
        end
        return s >> 1;
    endfunction

    // one lfsr step per bit taken
    task automatic random_word(output word_t w);
        w = '0;
        for (int b = 0; b < 32; b++) begin
            lfsr = lfsr_step(lfsr);
            w = {w[30:0], lfsr[0]};
        end
    endtask

    function automatic logic [DMEM_ADDR_BITS-1:0] word_index(input word_t addr);
        return addr[DMEM_ADDR_BITS+1:2];
    endfunction

    function automatic bit returns_data(input mem_op_t op);
        return op inside {MEM_LB, MEM_LBU, MEM_LH, MEM_LHU, MEM_LW, MEM_AMOSWAP_W};
    endfunction

    // expected writeback value of a load from the low lanes of a word
    function automatic word_t load_value(input mem_op_t op, input word_t w);
        case (op)
            MEM_LB:  return w[7] ? (32'hffff_ff00 | {24'h0, w[7:0]}) : {24'h0, w[7:0]};
            MEM_LBU: return {24'h0, w[7:0]};
            MEM_LH:  return w[15] ? (32'hffff_0000 | {16'h0, w[15:0]}) : {16'h0, w[15:0]};
            MEM_LHU: return {16'h0, w[15:0]};
            default: return w;
        endcase
    endfunction

    task automatic ref_store(input mem_op_t op, input logic [DMEM_ADDR_BITS-1:0] idx,
                             input word_t data);
        word_t old;
        old = ref_mem[idx];
        case (op)
            MEM_SB:  ref_mem[idx] = {old[31:8], data[7:0]};
            MEM_SH:  ref_mem[idx] = {old[31:16], data[15:0]};
            default: ref_mem[idx] = data;
        endcase
    endtask

    task automatic add_entry(input mem_op_t op, input word_t addr, input word_t bits,
                             input int stall);
        tab_op[tab_count]    = op;
        tab_addr[tab_count]  = addr;
        tab_bits[tab_count]  = bits;
        tab_stall[tab_count] = stall;
        tab_count++;
    endtask

    task automatic load_table();
        tab_count = 0;
        add_entry(MEM_SW,        32'h0000_0010, 32'h0000_0000, 2);
        add_entry(MEM_LW,        32'h0000_0010, 32'h0000_0000, 4);
        // top bits of the two low lanes forced on for the extension cases
        add_entry(MEM_SW,        32'h0000_0020, 32'h0000_8080, 2);
        add_entry(MEM_LB,        32'h0000_0020, 32'h0000_0000, 4);
        add_entry(MEM_LBU,       32'h0000_0020, 32'h0000_0000, 4);
        add_entry(MEM_LH,        32'h0000_0020, 32'h0000_0000, 4);
        add_entry(MEM_LHU,       32'h0000_0020, 32'h0000_0000, 4);
        add_entry(MEM_SW,        32'h0000_0030, 32'h0000_0000, 2);
        add_entry(MEM_SB,        32'h0000_0030, 32'h0000_0000, 2);
        add_entry(MEM_LW,        32'h0000_0030, 32'h0000_0000, 4);
        add_entry(MEM_SH,        32'h0000_0030, 32'h0000_0000, 2);
        add_entry(MEM_LW,        32'h0000_0030, 32'h0000_0000, 4);
        add_entry(MEM_SW,        32'h0000_0040, 32'h0000_0000, 2);
        add_entry(MEM_AMOSWAP_W, 32'h0000_0040, 32'h0000_0000, 5);
        add_entry(MEM_LW,        32'h0000_0040, 32'h0000_0000, 4);
        add_entry(MEM_NONE,      32'h0000_0123, 32'h0000_0000, 0);
    endtask

    // store data and expected read data, in table order
    task automatic build_expected();
        word_t                     rnd;
        logic [DMEM_ADDR_BITS-1:0] idx;
        for (int i = 0; i < tab_count; i++) begin
            random_word(rnd);
            tab_wdata[i] = rnd | tab_bits[i];
            idx = word_index(tab_addr[i]);
            tab_rdata[i] = 32'h0;
            case (tab_op[i])
                MEM_SB, MEM_SH, MEM_SW: begin
                    ref_store(tab_op[i], idx, tab_wdata[i]);
                end
                MEM_AMOSWAP_W: begin
                    tab_rdata[i] = ref_mem[idx];
                    ref_mem[idx] = tab_wdata[i];
                end
                MEM_NONE: begin
                end
                default: begin
                    tab_rdata[i] = load_value(tab_op[i], ref_mem[idx]);
                end
            endcase
        end
    endtask

    task automatic check_word(input string name, input word_t got, input word_t exp);
        if (got !== exp) begin
            $display("error %s: got 0x%08h, expected 0x%08h", name, got, exp);
            errors++;
        end
    endtask

    task automatic check_count(input string name, input int got, input int exp);
        if (got != exp) begin
            $display("error %s: got 0x%0h, expected 0x%0h", name, got, exp);
            errors++;
        end
    endtask

    task automatic check_id(input string name, input inst_id_t got, input inst_id_t exp);
        if (got !== exp) begin
            $display("error %s: got 0x%016h, expected 0x%016h", name, got, exp);
            errors++;
        end
    endtask

    task automatic check_op(input string name, input mem_op_t got, input mem_op_t exp);
        if (got !== exp) begin
            $display("error %s: got 0x%0h, expected 0x%0h", name, got, exp);
            errors++;
        end
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            $display("error %s: got 0x%0h, expected 0x%0h", name, got, exp);
            errors++;
        end
    endtask

    // new instruction, a fresh tag every time
    task automatic drive_inst(input mem_op_t op, input word_t addr, input word_t wdata);
        word_t csr;
        random_word(csr);
        @(posedge clk);
        #1;
        cur_pc         = {next_id[29:0], 2'b00} + 32'h0000_1000;
        cur_inst       = {next_id[19:0], 12'h003};
        cur_id         = next_id;
        cur_op         = op;
        cur_addr       = addr;
        cur_csr        = csr;
        mem_valid      = 1'b1;
        mem_op         = op;
        mem_alu_out    = addr;
        mem_rs2_data   = wdata;
        mem_reg_pc     = cur_pc;
        mem_inst       = cur_inst;
        mem_inst_id    = cur_id;
        mem_csr_rdata  = cur_csr;
        pipeline_flush = 1'b0;
        next_id++;
    endtask

    // sampled at the falling edge, stall counted until writeback
    task automatic wait_for_wb(output int stall_cycles, output bit seen);
        int cycles;
        stall_cycles = 0;
        cycles = 0;
        seen = 1'b0;
        @(negedge clk);
        while (!seen && cycles < TIMEOUT_CYCLES) begin
            if (mem_wb_valid) begin
                seen = 1'b1;
            end else begin
                if (memory_unit_stall) begin
                    stall_cycles++;
                end
                cycles++;
                @(negedge clk);
            end
        end
    endtask

    task automatic check_passthrough();
        check_word("mem_wb_reg_pc", mem_wb_reg_pc, cur_pc);
        check_word("mem_wb_inst", mem_wb_inst, cur_inst);
        check_id("mem_wb_inst_id", mem_wb_inst_id, cur_id);
        check_op("mem_wb_op", mem_wb_op, cur_op);
        check_word("mem_wb_alu_out", mem_wb_alu_out, cur_addr);
        check_word("mem_wb_csr_rdata", mem_wb_csr_rdata, cur_csr);
    endtask

    task automatic finish_test(input int num, input string what, input int errors_before);
        tests_run++;
        if (errors == errors_before) begin
            tests_passed++;
            $display("test %0d %s: ok", num, what);
        end else begin
            $display("test %0d %s: failed", num, what);
        end
    endtask

    task automatic run_entry(input int i);
        mem_op_t op;
        int      stall_cycles;
        bit      seen;
        int      errors_before;
        op = tab_op[i];
        errors_before = errors;
        drive_inst(op, tab_addr[i], tab_wdata[i]);
        wait_for_wb(stall_cycles, seen);
        if (!seen) begin
            $display("test %0d %s timed out waiting for mem_wb_valid", i, op.name());
            tests_run++;
            timed_out = 1'b1;
        end else begin
            check_count("memory_unit_stall cycles", stall_cycles, tab_stall[i]);
            if (returns_data(op)) begin
                check_word("mem_wb_mem_rdata", mem_wb_mem_rdata, tab_rdata[i]);
            end
            check_passthrough();
            finish_test(i, op.name(), errors_before);
        end
    endtask

    // load abandoned by a flush, then a load while the memory may be busy
    task automatic run_flush_test(input int num);
        int    stall_cycles;
        bit    seen;
        int    errors_before;
        word_t expected;
        errors_before = errors;
        expected = load_value(MEM_LW, ref_mem[word_index(32'h0000_0030)]);
        drive_inst(MEM_LW, 32'h0000_0010, 32'h0);
        @(posedge clk);
        #1;
        @(posedge clk);
        #1;
        pipeline_flush = 1'b1;
        // flush held into the next cycle, where the abandoned load no longer stalls
        for (int c = 0; c < 2; c++) begin
            @(negedge clk);
            check_bit("mem_wb_valid", mem_wb_valid, 1'b0);
        end
        drive_inst(MEM_LW, 32'h0000_0030, 32'h0);
        wait_for_wb(stall_cycles, seen);
        if (!seen) begin
            $display("test %0d flush timed out waiting for mem_wb_valid", num);
            tests_run++;
            timed_out = 1'b1;
        end else begin
            check_word("mem_wb_mem_rdata", mem_wb_mem_rdata, expected);
            check_id("mem_wb_inst_id", mem_wb_inst_id, cur_id);
            finish_test(num, "flush", errors_before);
        end
    endtask

    initial begin
        reset          = 1'b1;
        mem_valid      = 1'b0;
        mem_reg_pc     = '0;
        mem_inst       = '0;
        mem_inst_id    = '0;
        mem_op         = MEM_NONE;
        mem_rs2_data   = '0;
        mem_alu_out    = '0;
        mem_csr_rdata  = '0;
        pipeline_flush = 1'b0;
        lfsr           = 16'd12;
        next_id        = 64'h1;
        errors         = 0;
        tests_run      = 0;
        tests_passed   = 0;
        timed_out      = 1'b0;

        repeat (16) @(posedge clk);
        #1;
        reset = 1'b0;

        load_table();
        build_expected();
        for (int i = 0; i < tab_count; i++) begin
            if (!timed_out) begin
                run_entry(i);
            end
        end
        if (!timed_out) begin
            run_flush_test(tab_count);
        end

        $display("tests %0d, passed %0d, failed %0d, errors %0d",
                 tests_run, tests_passed, tests_run - tests_passed, errors);
        if (errors == 0 && !timed_out && tests_passed == tab_count + 1) begin
            $display("=== PASS ===");
        end else begin
            $display("=== FAIL ===");
        end
        $finish;
    end

endmodule

//--- tb.f
source/core_pkg.sv
source/mem_stage.sv
source/data_sram.sv
source/mem_subsystem.sv
bench/tb_mem_subsystem.sv

//--- run_sim.sh
#!/bin/sh
# build and run the memory subsystem testbench with verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing -j 0 \
    --top-module tb_mem_subsystem \
    -f tb.f \
    -o tb_sim
status=$?
if [ $status -ne 0 ]; then
    echo "verilator build failed with status $status"
    exit 1
fi

./obj_dir/tb_sim > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "=== FAIL ===" "$LOG"; then
    echo "simulation reported failure"
    exit 1
fi

if ! grep -q "=== PASS ===" "$LOG"; then
    echo "no result found in $LOG"
    exit 1
fi

exit 0
